//--- exec_defs.svh
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// integer datapath width
`define XLEN 32

// restoring divider iterations, one per quotient bit
`define DIV_STEPS `XLEN

`endif

//--- isa_pkg.sv
package isa_pkg;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_format_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_format_t;

  // one instruction word, read as register or immediate format
  typedef union packed {
    r_format_t r_format;
    i_format_t i_format;
  } instr_t;

  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

  localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // base integer group
  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_SLL     = 3'b001;
  localparam logic [2:0] FUNCT3_SLT     = 3'b010;
  localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_SR      = 3'b101;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;

  // upper half of the M extension
  localparam logic [2:0] FUNCT3_DIV  = 3'b100;
  localparam logic [2:0] FUNCT3_DIVU = 3'b101;
  localparam logic [2:0] FUNCT3_REM  = 3'b110;
  localparam logic [2:0] FUNCT3_REMU = 3'b111;

endpackage

//--- exec_pkg.sv
package exec_pkg;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  typedef enum logic [1:0] {
    div_div,
    div_divu,
    div_rem,
    div_remu
  } div_op_t;

  // values follow mcause
  typedef enum logic [3:0] {
    ecause_none                = 4'd0,
    ecause_illegal_instruction = 4'd2
  } ecause_t;

endpackage

//--- lane_alu.sv
`include "exec_defs.svh"

module lane_alu (
  input  logic              issue_valid,
  input  isa_pkg::instr_t   instr,
  input  logic [`XLEN-1:0]  rs1_data,
  input  logic [`XLEN-1:0]  rs2_data,
  input  logic              div_done,
  input  logic [`XLEN-1:0]  div_result,
  output logic [`XLEN-1:0]  result,
  output logic [4:0]        rd,
  output logic              wren,
  output logic              exception,
  output exec_pkg::ecause_t ecause,
  output logic              div_req,
  output exec_pkg::div_op_t div_op,
  output logic [`XLEN-1:0]  div_dividend,
  output logic [`XLEN-1:0]  div_divisor,
  output logic              div_wait
);
  import isa_pkg::*;
  import exec_pkg::*;

  alu_op_t alu_op;
  logic is_imm;
  logic is_div;
  logic illegal;
  logic [`XLEN-1:0] imm_ext;
  logic [`XLEN-1:0] operand_b;
  logic [`XLEN-1:0] alu_result;
  logic [$clog2(`XLEN)-1:0] shamt;

  always_comb begin
    alu_op = alu_add;
    div_op = div_div;
    is_imm = 1'b0;
    is_div = 1'b0;
    illegal = 1'b0;
    case (instr.r_format.opcode)
      OPCODE_OP: begin
        case ({instr.r_format.funct7, instr.r_format.funct3})
          {FUNCT7_BASE, FUNCT3_ADD_SUB}: alu_op = alu_add;
          {FUNCT7_ALT, FUNCT3_ADD_SUB}: alu_op = alu_sub;
          {FUNCT7_BASE, FUNCT3_SLL}: alu_op = alu_sll;
          {FUNCT7_BASE, FUNCT3_SLT}: alu_op = alu_slt;
          {FUNCT7_BASE, FUNCT3_SLTU}: alu_op = alu_sltu;
          {FUNCT7_BASE, FUNCT3_XOR}: alu_op = alu_xor;
          {FUNCT7_BASE, FUNCT3_SR}: alu_op = alu_srl;
          {FUNCT7_ALT, FUNCT3_SR}: alu_op = alu_sra;
          {FUNCT7_BASE, FUNCT3_OR}: alu_op = alu_or;
          {FUNCT7_BASE, FUNCT3_AND}: alu_op = alu_and;
          {FUNCT7_MULDIV, FUNCT3_DIV}: begin
            is_div = 1'b1;
            div_op = div_div;
          end
          {FUNCT7_MULDIV, FUNCT3_DIVU}: begin
            is_div = 1'b1;
            div_op = div_divu;
          end
          {FUNCT7_MULDIV, FUNCT3_REM}: begin
            is_div = 1'b1;
            div_op = div_rem;
          end
          {FUNCT7_MULDIV, FUNCT3_REMU}: begin
            is_div = 1'b1;
            div_op = div_remu;
          end
          // multiply and unknown funct7 land here
          default: illegal = 1'b1;
        endcase
      end
      OPCODE_OP_IMM: begin
        is_imm = 1'b1;
        case (instr.i_format.funct3)
          FUNCT3_ADD_SUB: alu_op = alu_add;
          FUNCT3_SLT: alu_op = alu_slt;
          FUNCT3_SLTU: alu_op = alu_sltu;
          FUNCT3_XOR: alu_op = alu_xor;
          FUNCT3_OR: alu_op = alu_or;
          FUNCT3_AND: alu_op = alu_and;
          // shift immediates are not part of this stage
          default: illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase
    exception = issue_valid & illegal;
    div_req = issue_valid & is_div;
  end

  assign imm_ext = {{(`XLEN-12){instr.i_format.imm12[11]}}, instr.i_format.imm12};
  assign operand_b = is_imm ? imm_ext : rs2_data;
  assign shamt = operand_b[$clog2(`XLEN)-1:0];

  always_comb begin
    case (alu_op)
      alu_add: alu_result = rs1_data + operand_b;
      alu_sub: alu_result = rs1_data - operand_b;
      alu_sll: alu_result = rs1_data << shamt;
      alu_slt: alu_result = {{(`XLEN-1){1'b0}}, $signed(rs1_data) < $signed(operand_b)};
      alu_sltu: alu_result = {{(`XLEN-1){1'b0}}, rs1_data < operand_b};
      alu_xor: alu_result = rs1_data ^ operand_b;
      alu_srl: alu_result = rs1_data >> shamt;
      alu_sra: alu_result = $signed(rs1_data) >>> shamt;
      alu_or: alu_result = rs1_data | operand_b;
      alu_and: alu_result = rs1_data & operand_b;
      default: alu_result = '0;
    endcase
  end

  assign rd = instr.r_format.rd;
  assign wren = issue_valid & ~illegal & (rd != 5'd0);
  assign ecause = exception ? ecause_illegal_instruction : ecause_none;
  assign div_dividend = rs1_data;
  assign div_divisor = rs2_data;
  // lane holds the stage until its quotient or remainder is parked
  assign div_wait = div_req & ~div_done;
  assign result = (is_div && div_done) ? div_result : alu_result;

endmodule

//--- div_arbiter.sv
`include "exec_defs.svh"

module div_arbiter (
  input  logic              clock,
  input  logic              reset,
  input  logic              advance,
  input  logic              req0,
  input  logic              req1,
  input  exec_pkg::div_op_t op0,
  input  exec_pkg::div_op_t op1,
  input  logic [`XLEN-1:0]  dividend0,
  input  logic [`XLEN-1:0]  dividend1,
  input  logic [`XLEN-1:0]  divisor0,
  input  logic [`XLEN-1:0]  divisor1,
  input  logic              div_busy,
  input  logic              div_done,
  input  logic [`XLEN-1:0]  div_result,
  output logic              start,
  output exec_pkg::div_op_t op,
  output logic [`XLEN-1:0]  dividend,
  output logic [`XLEN-1:0]  divisor,
  output logic              done0,
  output logic              done1,
  output logic [`XLEN-1:0]  result0,
  output logic [`XLEN-1:0]  result1
);

  logic owner_valid;
  logic owner_lane;
  logic want0;
  logic want1;
  logic grant_lane;

  // a lane wants the divider until its result is parked
  assign want0 = req0 & ~done0;
  assign want1 = req1 & ~done1;
  // lane 0 goes first
  assign grant_lane = ~want0;
  assign start = ~div_busy & ~owner_valid & (want0 | want1);
  assign op = grant_lane ? op1 : op0;
  assign dividend = grant_lane ? dividend1 : dividend0;
  assign divisor = grant_lane ? divisor1 : divisor0;

  always_ff @(posedge clock) begin
    if (!reset) begin
      owner_valid <= 1'b0;
      owner_lane <= 1'b0;
      done0 <= 1'b0;
      done1 <= 1'b0;
    end else begin
      if (start) begin
        owner_valid <= 1'b1;
        owner_lane <= grant_lane;
      end else if (div_done) begin
        owner_valid <= 1'b0;
      end
      if (advance) begin
        done0 <= 1'b0;
        done1 <= 1'b0;
      end else if (div_done) begin
        done0 <= done0 | ~owner_lane;
        done1 <= done1 | owner_lane;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (div_done && !owner_lane) begin
      result0 <= div_result;
    end
    if (div_done && owner_lane) begin
      result1 <= div_result;
    end
  end

  // the divider answers within its worst case latency
  assert property (@(posedge clock) disable iff (!reset)
    start |-> ##[1:`DIV_STEPS+2] div_done)
    else $error("div_arbiter: divider never finished");

  assert property (@(posedge clock) disable iff (!reset) div_done |-> owner_valid)
    else $error("div_arbiter: divider result with no owning lane");

endmodule

//--- serial_divider.sv
`include "exec_defs.svh"

module serial_divider (
  input  logic              clock,
  input  logic              reset,
  input  logic              start,
  input  exec_pkg::div_op_t op,
  input  logic [`XLEN-1:0]  dividend,
  input  logic [`XLEN-1:0]  divisor,
  output logic              busy,
  output logic              done,
  output logic [`XLEN-1:0]  result
);
  import exec_pkg::*;

  logic stepping;
  logic fixing;
  logic [$clog2(`DIV_STEPS)-1:0] count;
  logic [`XLEN-1:0] quot;
  logic [`XLEN-1:0] rem_acc;
  logic [`XLEN-1:0] divisor_mag;
  logic neg_quot;
  logic neg_rem;
  logic want_rem;
  logic is_signed;
  logic dividend_neg;
  logic divisor_neg;
  logic [`XLEN:0] rem_shift;
  logic [`XLEN:0] trial;

  assign is_signed = (op == div_div) || (op == div_rem);
  assign dividend_neg = is_signed & dividend[`XLEN-1];
  assign divisor_neg = is_signed & divisor[`XLEN-1];
  assign busy = stepping | fixing;

  // shift the next dividend bit in and try the subtraction
  assign rem_shift = {rem_acc, quot[`XLEN-1]};
  assign trial = rem_shift - {1'b0, divisor_mag};

  always_ff @(posedge clock) begin
    if (!reset) begin
      stepping <= 1'b0;
      fixing <= 1'b0;
      done <= 1'b0;
      count <= '0;
    end else begin
      done <= 1'b0;
      if (start && !busy) begin
        if (divisor == '0) begin
          done <= 1'b1;
        end else begin
          stepping <= 1'b1;
          count <= '0;
        end
      end else if (stepping) begin
        count <= count + 1'b1;
        if (count == ($clog2(`DIV_STEPS))'(`DIV_STEPS - 1)) begin
          stepping <= 1'b0;
          fixing <= 1'b1;
        end
      end else if (fixing) begin
        fixing <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start && !busy) begin
      quot <= dividend_neg ? -dividend : dividend;
      rem_acc <= '0;
      divisor_mag <= divisor_neg ? -divisor : divisor;
      neg_quot <= dividend_neg ^ divisor_neg;
      neg_rem <= dividend_neg;
      want_rem <= (op == div_rem) || (op == div_remu);
      // divide by zero answer, replaced later for a real divide
      result <= ((op == div_rem) || (op == div_remu)) ? dividend : '1;
    end else if (stepping) begin
      if (!trial[`XLEN]) begin
        rem_acc <= trial[`XLEN-1:0];
        quot <= {quot[`XLEN-2:0], 1'b1};
      end else begin
        rem_acc <= rem_shift[`XLEN-1:0];
        quot <= {quot[`XLEN-2:0], 1'b0};
      end
    end else if (fixing) begin
      // most negative / -1 negates back to the dividend with remainder 0
      if (want_rem) begin
        result <= neg_rem ? -rem_acc : rem_acc;
      end else begin
        result <= neg_quot ? -quot : quot;
      end
    end
  end

  assert property (@(posedge clock) disable iff (!reset) done |=> !done)
    else $error("serial_divider: done held longer than one cycle");

endmodule

//--- execute_stage.sv
`include "exec_defs.svh"

module execute_stage (
  input  logic              clock,
  input  logic              reset,
  input  logic              issue_valid,
  input  isa_pkg::instr_t   lane0_instr,
  input  logic [`XLEN-1:0]  lane0_rs1_data,
  input  logic [`XLEN-1:0]  lane0_rs2_data,
  input  isa_pkg::instr_t   lane1_instr,
  input  logic [`XLEN-1:0]  lane1_rs1_data,
  input  logic [`XLEN-1:0]  lane1_rs2_data,
  output logic              stall,
  output logic              out_valid,
  output logic [`XLEN-1:0]  lane0_result,
  output logic [4:0]        lane0_rd,
  output logic              lane0_wren,
  output logic              lane0_exception,
  output exec_pkg::ecause_t lane0_ecause,
  output logic [`XLEN-1:0]  lane1_result,
  output logic [4:0]        lane1_rd,
  output logic              lane1_wren,
  output logic              lane1_exception,
  output exec_pkg::ecause_t lane1_ecause
);
  import exec_pkg::*;

  logic advance;
  logic lane1_issue;
  logic [`XLEN-1:0] l0_result, l1_result;
  logic [4:0] l0_rd, l1_rd;
  logic l0_wren, l1_wren;
  logic l0_exception, l1_exception;
  ecause_t l0_ecause, l1_ecause;
  logic l0_div_req, l1_div_req;
  div_op_t l0_div_op, l1_div_op;
  logic [`XLEN-1:0] l0_dividend, l1_dividend;
  logic [`XLEN-1:0] l0_divisor, l1_divisor;
  logic l0_wait, l1_wait;
  logic done0, done1;
  logic [`XLEN-1:0] result0, result1;
  logic div_start;
  logic div_busy;
  logic div_done;
  div_op_t div_op;
  logic [`XLEN-1:0] div_dividend, div_divisor, div_result;

  // an exception on lane 0 kills lane 1 before it writes, traps or divides
  assign lane1_issue = issue_valid & ~l0_exception;
  assign stall = issue_valid & (l0_wait | l1_wait);
  assign advance = issue_valid & ~stall;

  lane_alu lane0 (
    .issue_valid  (issue_valid),
    .instr        (lane0_instr),
    .rs1_data     (lane0_rs1_data),
    .rs2_data     (lane0_rs2_data),
    .div_done     (done0),
    .div_result   (result0),
    .result       (l0_result),
    .rd           (l0_rd),
    .wren         (l0_wren),
    .exception    (l0_exception),
    .ecause       (l0_ecause),
    .div_req      (l0_div_req),
    .div_op       (l0_div_op),
    .div_dividend (l0_dividend),
    .div_divisor  (l0_divisor),
    .div_wait     (l0_wait)
  );

  lane_alu lane1 (
    .issue_valid  (lane1_issue),
    .instr        (lane1_instr),
    .rs1_data     (lane1_rs1_data),
    .rs2_data     (lane1_rs2_data),
    .div_done     (done1),
    .div_result   (result1),
    .result       (l1_result),
    .rd           (l1_rd),
    .wren         (l1_wren),
    .exception    (l1_exception),
    .ecause       (l1_ecause),
    .div_req      (l1_div_req),
    .div_op       (l1_div_op),
    .div_dividend (l1_dividend),
    .div_divisor  (l1_divisor),
    .div_wait     (l1_wait)
  );

  div_arbiter arbiter0 (
    .clock      (clock),
    .reset      (reset),
    .advance    (advance),
    .req0       (l0_div_req),
    .req1       (l1_div_req),
    .op0        (l0_div_op),
    .op1        (l1_div_op),
    .dividend0  (l0_dividend),
    .dividend1  (l1_dividend),
    .divisor0   (l0_divisor),
    .divisor1   (l1_divisor),
    .div_busy   (div_busy),
    .div_done   (div_done),
    .div_result (div_result),
    .start      (div_start),
    .op         (div_op),
    .dividend   (div_dividend),
    .divisor    (div_divisor),
    .done0      (done0),
    .done1      (done1),
    .result0    (result0),
    .result1    (result1)
  );

  serial_divider divider0 (
    .clock    (clock),
    .reset    (reset),
    .start    (div_start),
    .op       (div_op),
    .dividend (div_dividend),
    .divisor  (div_divisor),
    .busy     (div_busy),
    .done     (div_done),
    .result   (div_result)
  );

  always_ff @(posedge clock) begin
    if (!reset) begin
      out_valid <= 1'b0;
      lane0_wren <= 1'b0;
      lane0_exception <= 1'b0;
      lane1_wren <= 1'b0;
      lane1_exception <= 1'b0;
    end else begin
      out_valid <= advance;
      lane0_wren <= advance & l0_wren;
      lane0_exception <= advance & l0_exception;
      lane1_wren <= advance & l1_wren;
      lane1_exception <= advance & l1_exception;
    end
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      lane0_result <= l0_result;
      lane0_rd <= l0_rd;
      lane0_ecause <= l0_ecause;
      lane1_result <= l1_result;
      lane1_rd <= l1_rd;
      lane1_ecause <= l1_ecause;
    end
  end

  // a stalled issue stays presented unchanged until it is accepted
  assert property (@(posedge clock) disable iff (!reset)
    stall |=> issue_valid && $stable(lane0_instr) && $stable(lane0_rs1_data)
      && $stable(lane0_rs2_data) && $stable(lane1_instr) && $stable(lane1_rs1_data)
      && $stable(lane1_rs2_data))
    else $error("execute_stage: issue inputs changed while stalled");

endmodule

//--- tb_execute_stage.sv
`include "exec_defs.svh"

module tb_execute_stage;
  import isa_pkg::*;
  import exec_pkg::*;

  localparam int PERIOD = 100;
  localparam int MAX_ENTRIES = 48;
  localparam int WAIT_LIMIT = 200;

  logic clock;
  logic reset;
  logic issue_valid;
  instr_t lane0_instr;
  instr_t lane1_instr;
  logic [`XLEN-1:0] lane0_rs1_data, lane0_rs2_data;
  logic [`XLEN-1:0] lane1_rs1_data, lane1_rs2_data;
  logic stall;
  logic out_valid;
  logic [`XLEN-1:0] lane0_result, lane1_result;
  logic [4:0] lane0_rd, lane1_rd;
  logic lane0_wren, lane1_wren;
  logic lane0_exception, lane1_exception;
  ecause_t lane0_ecause, lane1_ecause;

  string t_name [MAX_ENTRIES];
  instr_t t_instr0 [MAX_ENTRIES];
  instr_t t_instr1 [MAX_ENTRIES];
  logic [`XLEN-1:0] t_a0 [MAX_ENTRIES];
  logic [`XLEN-1:0] t_b0 [MAX_ENTRIES];
  logic [`XLEN-1:0] t_a1 [MAX_ENTRIES];
  logic [`XLEN-1:0] t_b1 [MAX_ENTRIES];
  logic [`XLEN-1:0] t_exp0 [MAX_ENTRIES];
  logic [`XLEN-1:0] t_exp1 [MAX_ENTRIES];
  logic t_legal0 [MAX_ENTRIES];
  logic t_legal1 [MAX_ENTRIES];
  logic t_stall [MAX_ENTRIES];
  int n_entries;
  int value_errors;
  int other_errors;

  execute_stage dut0 (
    .clock           (clock),
    .reset           (reset),
    .issue_valid     (issue_valid),
    .lane0_instr     (lane0_instr),
    .lane0_rs1_data  (lane0_rs1_data),
    .lane0_rs2_data  (lane0_rs2_data),
    .lane1_instr     (lane1_instr),
    .lane1_rs1_data  (lane1_rs1_data),
    .lane1_rs2_data  (lane1_rs2_data),
    .stall           (stall),
    .out_valid       (out_valid),
    .lane0_result    (lane0_result),
    .lane0_rd        (lane0_rd),
    .lane0_wren      (lane0_wren),
    .lane0_exception (lane0_exception),
    .lane0_ecause    (lane0_ecause),
    .lane1_result    (lane1_result),
    .lane1_rd        (lane1_rd),
    .lane1_wren      (lane1_wren),
    .lane1_exception (lane1_exception),
    .lane1_ecause    (lane1_ecause)
  );

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  function automatic instr_t r_instr(input logic [6:0] f7, input logic [2:0] f3,
      input logic [4:0] rd);
    instr_t w;
    w.r_format.funct7 = f7;
    w.r_format.rs2 = 5'd2;
    w.r_format.rs1 = 5'd1;
    w.r_format.funct3 = f3;
    w.r_format.rd = rd;
    w.r_format.opcode = OPCODE_OP;
    return w;
  endfunction

  function automatic instr_t i_instr(input logic [11:0] imm, input logic [2:0] f3,
      input logic [4:0] rd);
    instr_t w;
    w.i_format.imm12 = imm;
    w.i_format.rs1 = 5'd3;
    w.i_format.funct3 = f3;
    w.i_format.rd = rd;
    w.i_format.opcode = OPCODE_OP_IMM;
    return w;
  endfunction

  // RV32 reference, returns legality, result and whether the divider is needed
  function automatic logic ref_model(input instr_t ins, input logic [`XLEN-1:0] a,
      input logic [`XLEN-1:0] b, output logic [`XLEN-1:0] res, output logic is_div);
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] most_neg;
    logic overflow;
    logic legal;
    imm = `XLEN'($signed(ins.i_format.imm12));
    most_neg = {1'b1, {(`XLEN-1){1'b0}}};
    overflow = (a == most_neg) && (b == '1);
    legal = 1'b1;
    is_div = 1'b0;
    res = '0;
    if (ins.r_format.opcode == OPCODE_OP && ins.r_format.funct7 == FUNCT7_MULDIV) begin
      is_div = 1'b1;
      case (ins.r_format.funct3)
        FUNCT3_DIV: begin
          if (b == '0) res = '1;
          else if (overflow) res = a;
          else res = $signed(a) / $signed(b);
        end
        FUNCT3_DIVU: begin
          if (b == '0) res = '1;
          else res = a / b;
        end
        FUNCT3_REM: begin
          if (b == '0) res = a;
          else if (overflow) res = '0;
          else res = $signed(a) % $signed(b);
        end
        FUNCT3_REMU: begin
          if (b == '0) res = a;
          else res = a % b;
        end
        // multiply is not supported
        default: begin
          legal = 1'b0;
          is_div = 1'b0;
        end
      endcase
    end else if (ins.r_format.opcode == OPCODE_OP) begin
      case ({ins.r_format.funct7, ins.r_format.funct3})
        {FUNCT7_BASE, FUNCT3_ADD_SUB}: res = a + b;
        {FUNCT7_ALT, FUNCT3_ADD_SUB}: res = a - b;
        {FUNCT7_BASE, FUNCT3_SLL}: res = a << b[4:0];
        {FUNCT7_BASE, FUNCT3_SLT}: res = `XLEN'($signed(a) < $signed(b));
        {FUNCT7_BASE, FUNCT3_SLTU}: res = `XLEN'(a < b);
        {FUNCT7_BASE, FUNCT3_XOR}: res = a ^ b;
        {FUNCT7_BASE, FUNCT3_SR}: res = a >> b[4:0];
        {FUNCT7_ALT, FUNCT3_SR}: res = $signed(a) >>> b[4:0];
        {FUNCT7_BASE, FUNCT3_OR}: res = a | b;
        {FUNCT7_BASE, FUNCT3_AND}: res = a & b;
        default: legal = 1'b0;
      endcase
    end else if (ins.i_format.opcode == OPCODE_OP_IMM) begin
      case (ins.i_format.funct3)
        FUNCT3_ADD_SUB: res = a + imm;
        FUNCT3_SLT: res = `XLEN'($signed(a) < $signed(imm));
        FUNCT3_SLTU: res = `XLEN'(a < imm);
        FUNCT3_XOR: res = a ^ imm;
        FUNCT3_OR: res = a | imm;
        FUNCT3_AND: res = a & imm;
        default: legal = 1'b0;
      endcase
    end else begin
      legal = 1'b0;
    end
    return legal;
  endfunction

  task automatic add_entry(input string name, input instr_t i0, input logic [`XLEN-1:0] a0,
      input logic [`XLEN-1:0] b0, input instr_t i1, input logic [`XLEN-1:0] a1,
      input logic [`XLEN-1:0] b1);
    logic [`XLEN-1:0] r0, r1;
    logic d0, d1;
    if (n_entries >= MAX_ENTRIES) begin
      $display("table full, entry %s dropped", name);
      other_errors++;
      return;
    end
    t_name[n_entries] = name;
    t_instr0[n_entries] = i0;
    t_instr1[n_entries] = i1;
    t_a0[n_entries] = a0;
    t_b0[n_entries] = b0;
    t_a1[n_entries] = a1;
    t_b1[n_entries] = b1;
    t_legal0[n_entries] = ref_model(i0, a0, b0, r0, d0);
    t_legal1[n_entries] = ref_model(i1, a1, b1, r1, d1);
    t_exp0[n_entries] = r0;
    t_exp1[n_entries] = r1;
    // lane 1 cannot divide once lane 0 traps
    t_stall[n_entries] = d0 | (t_legal0[n_entries] & d1);
    n_entries++;
  endtask

  task automatic build_table();
    instr_t bad;
    bad = r_instr(FUNCT7_BASE, FUNCT3_ADD_SUB, 5'd5);
    bad.r_format.opcode = 7'b1110011;
    add_entry("add_sub", r_instr(FUNCT7_BASE, FUNCT3_ADD_SUB, 5'd5), 32'd7, 32'd9,
      r_instr(FUNCT7_ALT, FUNCT3_ADD_SUB, 5'd6), 32'd3, 32'd10);
    add_entry("sll_srl", r_instr(FUNCT7_BASE, FUNCT3_SLL, 5'd1), 32'h8000_0001, 32'd33,
      r_instr(FUNCT7_BASE, FUNCT3_SR, 5'd2), 32'hf000_0000, 32'd4);
    add_entry("sra_slt", r_instr(FUNCT7_ALT, FUNCT3_SR, 5'd3), 32'h8000_0000, 32'd31,
      r_instr(FUNCT7_BASE, FUNCT3_SLT, 5'd4), 32'hffff_fffe, 32'd1);
    add_entry("sltu_xor", r_instr(FUNCT7_BASE, FUNCT3_SLTU, 5'd7), 32'hffff_fffe, 32'd1,
      r_instr(FUNCT7_BASE, FUNCT3_XOR, 5'd8), 32'haaaa_5555, 32'h0ff0_0ff0);
    add_entry("or_rd0_and", r_instr(FUNCT7_BASE, FUNCT3_OR, 5'd0), 32'd12, 32'd3,
      r_instr(FUNCT7_BASE, FUNCT3_AND, 5'd9), 32'h0000_f0f0, 32'h0000_ff00);
    add_entry("addi_neg", i_instr(12'hfff, FUNCT3_ADD_SUB, 5'd10), 32'd5, 32'd0,
      i_instr(12'h800, FUNCT3_ADD_SUB, 5'd11), 32'd0, 32'd0);
    add_entry("slti_sltiu", i_instr(12'hfff, FUNCT3_SLT, 5'd12), 32'd0, 32'd0,
      i_instr(12'hfff, FUNCT3_SLTU, 5'd13), 32'd5, 32'd0);
    add_entry("xori_ori", i_instr(12'h0f0, FUNCT3_XOR, 5'd14), 32'h1234_5678, 32'd0,
      i_instr(12'h801, FUNCT3_OR, 5'd15), 32'h0000_0010, 32'd0);
    add_entry("andi_addi", i_instr(12'hf0f, FUNCT3_AND, 5'd16), 32'h1234_5678, 32'd0,
      i_instr(12'h7ff, FUNCT3_ADD_SUB, 5'd17), 32'd1, 32'd0);
    add_entry("div_signed", r_instr(FUNCT7_MULDIV, FUNCT3_DIV, 5'd18), -32'sd20, 32'd3,
      r_instr(FUNCT7_BASE, FUNCT3_ADD_SUB, 5'd19), 32'd1, 32'd2);
    add_entry("divu", r_instr(FUNCT7_MULDIV, FUNCT3_DIVU, 5'd18), 32'hffff_fff0, 32'd3,
      i_instr(12'h003, FUNCT3_ADD_SUB, 5'd19), 32'd4, 32'd0);
    add_entry("rem_signed", r_instr(FUNCT7_MULDIV, FUNCT3_REM, 5'd18), -32'sd20, 32'd3,
      r_instr(FUNCT7_BASE, FUNCT3_XOR, 5'd19), 32'd6, 32'd3);
    add_entry("remu", r_instr(FUNCT7_MULDIV, FUNCT3_REMU, 5'd18), 32'd100, 32'd7,
      r_instr(FUNCT7_BASE, FUNCT3_OR, 5'd19), 32'd8, 32'd1);
    add_entry("div_by_zero", r_instr(FUNCT7_MULDIV, FUNCT3_DIV, 5'd20), 32'd42, 32'd0,
      r_instr(FUNCT7_BASE, FUNCT3_AND, 5'd21), 32'hff, 32'h0f);
    add_entry("remu_by_zero", r_instr(FUNCT7_MULDIV, FUNCT3_REMU, 5'd20), -32'sd5, 32'd0,
      r_instr(FUNCT7_BASE, FUNCT3_SLT, 5'd21), 32'd1, 32'd2);
    add_entry("div_overflow", r_instr(FUNCT7_MULDIV, FUNCT3_DIV, 5'd22), 32'h8000_0000,
      32'hffff_ffff, r_instr(FUNCT7_BASE, FUNCT3_SLL, 5'd23), 32'd1, 32'd4);
    add_entry("rem_overflow", r_instr(FUNCT7_MULDIV, FUNCT3_REM, 5'd22), 32'h8000_0000,
      32'hffff_ffff, r_instr(FUNCT7_BASE, FUNCT3_SR, 5'd23), 32'd64, 32'd2);
    add_entry("dual_div", r_instr(FUNCT7_MULDIV, FUNCT3_DIV, 5'd24), 32'd1000, -32'sd7,
      r_instr(FUNCT7_MULDIV, FUNCT3_REMU, 5'd25), 32'd1000, 32'd7);
    add_entry("alu_then_div", r_instr(FUNCT7_BASE, FUNCT3_ADD_SUB, 5'd24), 32'd5, 32'd6,
      r_instr(FUNCT7_MULDIV, FUNCT3_DIVU, 5'd25), 32'd77, 32'd5);
    add_entry("dual_div_zero", r_instr(FUNCT7_MULDIV, FUNCT3_REM, 5'd26), 32'd9, 32'd0,
      r_instr(FUNCT7_MULDIV, FUNCT3_DIV, 5'd27), -32'sd9, 32'd2);
    add_entry("illegal_opcode_l0", bad, 32'd1, 32'd2,
      r_instr(FUNCT7_BASE, FUNCT3_ADD_SUB, 5'd28), 32'd3, 32'd4);
    add_entry("mul_l0_div_l1", r_instr(FUNCT7_MULDIV, 3'b000, 5'd29), 32'd3, 32'd4,
      r_instr(FUNCT7_MULDIV, FUNCT3_DIV, 5'd30), 32'd50, 32'd5);
    add_entry("illegal_l1", r_instr(FUNCT7_BASE, FUNCT3_ADD_SUB, 5'd31), 32'd11, 32'd22,
      i_instr(12'h005, FUNCT3_SLL, 5'd1), 32'd1, 32'd0);
    add_entry("bad_funct7_l0", r_instr(7'b0000010, FUNCT3_ADD_SUB, 5'd2), 32'd1, 32'd1,
      r_instr(FUNCT7_ALT, FUNCT3_ADD_SUB, 5'd3), 32'd9, 32'd4);
    for (int i = 0; i < 10; i++) begin
      add_entry($sformatf("rand_alu_%0d", i), r_instr(FUNCT7_BASE, 3'($urandom), 5'($urandom)),
        $urandom, $urandom, i_instr(12'($urandom), 3'($urandom), 5'($urandom)),
        $urandom, $urandom);
    end
    for (int i = 0; i < 4; i++) begin
      add_entry($sformatf("rand_div_%0d", i), r_instr(FUNCT7_MULDIV, {1'b1, 2'($urandom)},
        5'($urandom)), $urandom, $urandom >> ($urandom % 32),
        r_instr(FUNCT7_MULDIV, {1'b1, 2'($urandom)}, 5'($urandom)),
        $urandom, $urandom >> ($urandom % 32));
    end
  endtask

  task automatic compare_word(input string name, input string field,
      input logic [`XLEN-1:0] expected, input logic [`XLEN-1:0] actual);
    if (expected !== actual) begin
      $display("ERR %s %s expected %h actual %h", name, field, expected, actual);
      value_errors++;
    end
  endtask

  task automatic run_entry(input int k);
    int stall_cycles;
    int cycles;
    logic legal0;
    logic legal1;
    logic exc1;
    @(negedge clock);
    issue_valid = 1'b1;
    lane0_instr = t_instr0[k];
    lane0_rs1_data = t_a0[k];
    lane0_rs2_data = t_b0[k];
    lane1_instr = t_instr1[k];
    lane1_rs1_data = t_a1[k];
    lane1_rs2_data = t_b1[k];
    #1;
    stall_cycles = 0;
    while (stall && stall_cycles < WAIT_LIMIT) begin
      @(negedge clock);
      #1;
      stall_cycles++;
    end
    if (stall) begin
      $display("%s: stall did not drop within %0d cycles", t_name[k], WAIT_LIMIT);
      other_errors++;
    end
    compare_word(t_name[k], "stall_seen", t_stall[k], stall_cycles > 0);
    // accepted on the next rising edge, results expected by the following falling edge
    @(negedge clock);
    issue_valid = 1'b0;
    cycles = 0;
    while (!out_valid && cycles < WAIT_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    if (!out_valid) begin
      $display("%s: out_valid never arrived", t_name[k]);
      other_errors++;
      return;
    end
    compare_word(t_name[k], "out_valid_delay", 0, cycles);
    legal0 = t_legal0[k];
    legal1 = t_legal1[k];
    exc1 = legal0 & ~legal1;
    compare_word(t_name[k], "lane0_rd", t_instr0[k].r_format.rd, lane0_rd);
    compare_word(t_name[k], "lane0_wren", legal0 && t_instr0[k].r_format.rd != 0, lane0_wren);
    compare_word(t_name[k], "lane0_exception", !legal0, lane0_exception);
    compare_word(t_name[k], "lane0_ecause",
      legal0 ? ecause_none : ecause_illegal_instruction, lane0_ecause);
    if (legal0) begin
      compare_word(t_name[k], "lane0_result", t_exp0[k], lane0_result);
    end
    compare_word(t_name[k], "lane1_rd", t_instr1[k].r_format.rd, lane1_rd);
    compare_word(t_name[k], "lane1_wren",
      legal0 && legal1 && t_instr1[k].r_format.rd != 0, lane1_wren);
    compare_word(t_name[k], "lane1_exception", exc1, lane1_exception);
    compare_word(t_name[k], "lane1_ecause",
      exc1 ? ecause_illegal_instruction : ecause_none, lane1_ecause);
    if (legal0 && legal1) begin
      compare_word(t_name[k], "lane1_result", t_exp1[k], lane1_result);
    end
    @(negedge clock);
    if (out_valid) begin
      $display("%s: out_valid stayed high for a second cycle", t_name[k]);
      other_errors++;
    end
  endtask

  initial begin
    reset = 1'b0;
    issue_valid = 1'b0;
    lane0_instr = '0;
    lane1_instr = '0;
    lane0_rs1_data = '0;
    lane0_rs2_data = '0;
    lane1_rs1_data = '0;
    lane1_rs2_data = '0;
    n_entries = 0;
    value_errors = 0;
    other_errors = 0;
    void'($urandom(32'h088c_0217));
    build_table();
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    @(negedge clock);
    compare_word("after_reset", "out_valid", 0, out_valid);
    compare_word("after_reset", "stall", 0, stall);
    // a divide presented without issue_valid must stay invisible
    lane0_instr = r_instr(FUNCT7_MULDIV, FUNCT3_DIV, 5'd4);
    lane0_rs1_data = 32'd100;
    lane0_rs2_data = 32'd3;
    repeat (5) begin
      @(negedge clock);
      compare_word("idle_issue", "out_valid", 0, out_valid);
      compare_word("idle_issue", "stall", 0, stall);
    end
    for (int k = 0; k < n_entries; k++) begin
      run_entry(k);
    end
    $display("%0d entries run, %0d value errors, %0d other errors",
      n_entries, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- execute_stage.f
+incdir+.
isa_pkg.sv
exec_pkg.sv
lane_alu.sv
div_arbiter.sv
serial_divider.sv
execute_stage.sv
tb_execute_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_execute_stage
FILELIST  ?= execute_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Simulation PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it into $(LOG), check for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
